/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - logic
    files:
      - logic/cache_pkg.sv
      - logic/cache_line_store.sv
      - logic/cache_ctrl.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - verif/slow_mem_model.sv
      - verif/dcache_sva.sv
      - verif/dcache_tb.sv

/* dcache_top.f */
+incdir+logic
logic/cache_pkg.sv
logic/cache_line_store.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
verif/slow_mem_model.sv
verif/dcache_sva.sv
verif/dcache_tb.sv

/* logic/cache_ctrl.sv */
// controller with address split, hit detection, miss FSM, word select and memory requests

`timescale 1ns/10ps

module cache_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,

	// processor side
	input  logic                  i_proc_read,
	input  logic                  i_proc_write,
	input  cache_pkg::word_addr_t  i_proc_addr,
	input  cache_pkg::word_t       i_proc_wdata,
	output cache_pkg::word_t       o_proc_rdata,
	output logic                  o_proc_stall,

	// memory side
	output logic                  o_mem_read,
	output logic                  o_mem_write,
	output cache_pkg::line_addr_t  o_mem_addr,
	output cache_pkg::line_t       o_mem_wdata,
	input  cache_pkg::line_t       i_mem_rdata,
	input  logic                  i_mem_ready,

	// line store, addressed line
	input  logic                  i_line_valid,
	input  cache_pkg::tag_t        i_line_tag,
	input  cache_pkg::line_t       i_line,

	// line store, control
	output cache_pkg::index_t      o_index,
	output cache_pkg::offset_t     o_word_sel,
	output logic                  o_word_wr,
	output cache_pkg::word_t       o_wdata,
	output logic                  o_fill,
	output cache_pkg::tag_t        o_fill_tag,
	output cache_pkg::line_t       o_fill_line
);

	import cache_pkg::*;

	// ------------------------------------------------------------------------
	// address split and hit
	// ------------------------------------------------------------------------

	tag_t         req_tag;
	index_t       req_index;
	offset_t      req_offset;
	logic         req;
	logic         hit;
	cache_state_e state_q;
	cache_state_e state_d;

	assign {req_tag, req_index, req_offset} = i_proc_addr;

	assign req = i_proc_read | i_proc_write;	// never both
	assign hit = i_line_valid && (i_line_tag == req_tag);

	// stalls until the addressed line holds the right tag
	assign o_proc_stall = req & ~hit;

	// ------------------------------------------------------------------------
	// miss FSM
	// ------------------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_READY: begin
				if (req && !hit) begin
					// without a dirty bit every valid victim goes back out
					state_d = i_line_valid ? ST_WRITE_BACK : ST_FILL;
				end
			end
			ST_WRITE_BACK: begin
				if (i_mem_ready) begin
					state_d = ST_FILL;
				end
			end
			ST_FILL: begin
				if (i_mem_ready) begin
					state_d = ST_READY;	// hit on the next cycle
				end
			end
			default: begin
				state_d = ST_READY;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_READY;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------------------
	// memory requests
	// ------------------------------------------------------------------------

	// held stable from state and the held processor request until ready
	always_comb begin
		o_mem_read  = 1'b0;
		o_mem_write = 1'b0;
		o_mem_addr  = {req_tag, req_index};
		o_mem_wdata = '0;
		case (state_q)
			ST_WRITE_BACK: begin
				o_mem_write = 1'b1;
				o_mem_addr  = {i_line_tag, req_index};	// victim's own address
				o_mem_wdata = i_line;
			end
			ST_FILL: begin
				o_mem_read = 1'b1;
				o_mem_addr = {req_tag, req_index};
			end
			default: begin
				o_mem_read  = 1'b0;
				o_mem_write = 1'b0;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// line store control
	// ------------------------------------------------------------------------

	assign o_index    = req_index;
	assign o_word_sel = req_offset;
	assign o_wdata    = i_proc_wdata;

	// write lands at the accepting edge
	assign o_word_wr = (state_q == ST_READY) & i_proc_write & hit;

	// line, tag and valid written together at the ready edge
	assign o_fill      = (state_q == ST_FILL) & i_mem_ready;
	assign o_fill_tag  = req_tag;
	assign o_fill_line = i_mem_rdata;

	// read word select
	assign o_proc_rdata = i_line[req_offset*$bits(word_t) +: $bits(word_t)];

endmodule

/* logic/cache_line_store.sv */
// line store with valid bits, tags and data lines, word write and line fill

`timescale 1ns/10ps

`include "dcache_settings.svh"

module cache_line_store (
	input  logic              clk,
	input  logic              rst_n,

	// addressed line
	input  cache_pkg::index_t  i_index,

	// word write from a processor hit
	input  cache_pkg::offset_t i_word_sel,
	input  logic              i_word_wr,
	input  cache_pkg::word_t   i_wdata,

	// whole line from memory
	input  logic              i_fill,
	input  cache_pkg::tag_t    i_fill_tag,
	input  cache_pkg::line_t   i_fill_line,

	// contents of the addressed line
	output logic              o_valid,
	output cache_pkg::tag_t    o_tag,
	output cache_pkg::line_t   o_line
);

	import cache_pkg::*;

	localparam int NUM_LINES = 1 << `CACHE_INDEX_W;

	// ------------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------------

	logic [NUM_LINES-1:0] valid_q;	// one per line
	tag_t                 tag_q  [NUM_LINES];
	line_t                line_q [NUM_LINES];

	// ------------------------------------------------------------------------
	// valid bits
	// ------------------------------------------------------------------------

	// all lines start empty and only a fill sets a bit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (i_fill) begin
			valid_q[i_index] <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// tags
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (i_fill) begin
			tag_q[i_index] <= i_fill_tag;
		end
	end

	// ------------------------------------------------------------------------
	// data lines
	// ------------------------------------------------------------------------

	// a fill takes the whole line and a write hit patches one word
	always_ff @(posedge clk) begin
		if (i_fill) begin
			line_q[i_index] <= i_fill_line;
		end else if (i_word_wr) begin
			line_q[i_index][i_word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] <= i_wdata;
		end
	end

	// ------------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------------

	// combinational so a hit is answered in the same cycle
	always_comb begin
		o_valid = valid_q[i_index];
		o_tag   = tag_q[i_index];
		o_line  = line_q[i_index];
	end

endmodule

/* logic/cache_pkg.sv */
// package with the width typedefs and the controller state enum of the data cache

`include "dcache_settings.svh"

package cache_pkg;

	// ------------------------------------------------------------------------
	// payload widths
	// ------------------------------------------------------------------------

	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// word 0 in the low bits
	typedef logic [(`CACHE_WORD_W << `CACHE_OFFSET_W)-1:0] line_t;

	// ------------------------------------------------------------------------
	// address fields
	// ------------------------------------------------------------------------

	typedef logic [`CACHE_ADDR_W-1:0] word_addr_t;	// from the processor
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;	// word in line
	typedef logic [`CACHE_INDEX_W-1:0] index_t;	// line number

	// everything above index and offset
	typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-`CACHE_OFFSET_W-1:0] tag_t;

	// tag then index as seen by the line memory
	typedef logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] line_addr_t;

	// miss handling
	typedef enum logic [1:0] {
		ST_READY,	// idle or serving hits
		ST_WRITE_BACK,	// victim line going out
		ST_FILL	// new line coming in
	} cache_state_e;

endpackage

/* logic/dcache_settings.svh */
// data cache geometry macros: word, address, offset and index widths

`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ----------------------------------------------------------------------------
// word and address
// ----------------------------------------------------------------------------

`define CACHE_WORD_W	32	// bits per data word
`define CACHE_ADDR_W	30	// processor word address

// ----------------------------------------------------------------------------
// line geometry
// ----------------------------------------------------------------------------

// 4 words per line
`define CACHE_OFFSET_W	2

// 8 lines, direct mapped
`define CACHE_INDEX_W	3

`endif

/* logic/dcache_top.sv */
// data cache top level with the controller beside its line store

`timescale 1ns/10ps

module dcache_top (
	input  logic                  clk,
	input  logic                  rst_n,

	// processor port
	input  logic                  i_proc_read,
	input  logic                  i_proc_write,
	input  cache_pkg::word_addr_t  i_proc_addr,
	input  cache_pkg::word_t       i_proc_wdata,
	output cache_pkg::word_t       o_proc_rdata,
	output logic                  o_proc_stall,

	// line memory port
	output logic                  o_mem_read,
	output logic                  o_mem_write,
	output cache_pkg::line_addr_t  o_mem_addr,
	output cache_pkg::line_t       o_mem_wdata,
	input  cache_pkg::line_t       i_mem_rdata,
	input  logic                  i_mem_ready
);

	import cache_pkg::*;

	// ------------------------------------------------------------------------
	// controller to line store
	// ------------------------------------------------------------------------

	index_t  store_index;
	offset_t store_word_sel;
	logic    store_word_wr;
	word_t   store_wdata;
	logic    store_fill;
	tag_t    store_fill_tag;
	line_t   store_fill_line;

	logic    line_valid;	// addressed line as read back
	tag_t    line_tag;
	line_t   line_data;

	cache_ctrl cache_ctrl_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_proc_read  (i_proc_read),
		.i_proc_write (i_proc_write),
		.i_proc_addr  (i_proc_addr),
		.i_proc_wdata (i_proc_wdata),
		.o_proc_rdata (o_proc_rdata),
		.o_proc_stall (o_proc_stall),
		.o_mem_read   (o_mem_read),
		.o_mem_write  (o_mem_write),
		.o_mem_addr   (o_mem_addr),
		.o_mem_wdata  (o_mem_wdata),
		.i_mem_rdata  (i_mem_rdata),
		.i_mem_ready  (i_mem_ready),
		.i_line_valid (line_valid),
		.i_line_tag   (line_tag),
		.i_line       (line_data),
		.o_index      (store_index),
		.o_word_sel   (store_word_sel),
		.o_word_wr    (store_word_wr),
		.o_wdata      (store_wdata),
		.o_fill       (store_fill),
		.o_fill_tag   (store_fill_tag),
		.o_fill_line  (store_fill_line)
	);

	cache_line_store cache_line_store_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_index     (store_index),
		.i_word_sel  (store_word_sel),
		.i_word_wr   (store_word_wr),
		.i_wdata     (store_wdata),
		.i_fill      (store_fill),
		.i_fill_tag  (store_fill_tag),
		.i_fill_line (store_fill_line),
		.o_valid     (line_valid),
		.o_tag       (line_tag),
		.o_line      (line_data)
	);

endmodule

/* verif/dcache_sva.sv */
// bound assertions on the memory and processor handshakes of the data cache

`timescale 1ns/10ps

module dcache_sva (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  i_proc_read,
	input logic                  i_proc_write,
	input logic                  o_proc_stall,
	input logic                  o_mem_read,
	input logic                  o_mem_write,
	input cache_pkg::line_addr_t  o_mem_addr,
	input logic                  i_mem_ready
);

	int unsigned fail_count = 0;	// read back by the testbench

	// one memory operation at a time
	a_one_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
		!(o_mem_read && o_mem_write))
		else begin
			$error("memory read and write requested together");
			fail_count++;
		end

	// a request waits for ready with its address held
	a_read_held: assert property (@(posedge clk) disable iff (!rst_n)
		(o_mem_read && !i_mem_ready) |=> (o_mem_read && $stable(o_mem_addr)))
		else begin
			$error("memory read dropped or moved before ready");
			fail_count++;
		end

	a_write_held: assert property (@(posedge clk) disable iff (!rst_n)
		(o_mem_write && !i_mem_ready) |=> (o_mem_write && $stable(o_mem_addr)))
		else begin
			$error("memory write dropped or moved before ready");
			fail_count++;
		end

	// stall only answers a live request
	a_stall_req: assert property (@(posedge clk) disable iff (!rst_n)
		o_proc_stall |-> (i_proc_read || i_proc_write))
		else begin
			$error("stall raised with no processor request");
			fail_count++;
		end

endmodule

bind dcache_top dcache_sva dcache_sva_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.i_proc_read  (i_proc_read),
	.i_proc_write (i_proc_write),
	.o_proc_stall (o_proc_stall),
	.o_mem_read   (o_mem_read),
	.o_mem_write  (o_mem_write),
	.o_mem_addr   (o_mem_addr),
	.i_mem_ready  (i_mem_ready)
);

/* verif/dcache_tb.sv */
// data cache testbench with clock, reset, slow memory, stimulus table, shadow model and watchdog

`timescale 1ns/10ps

module dcache_tb;

	import cache_pkg::*;

	localparam int          CLK_PERIOD   = 40;
	localparam int          MEM_LATENCY  = 3;
	localparam int          N_DIRECTED   = 8;
	localparam int          N_RANDOM     = 24;
	localparam int          TABLE_LEN    = N_DIRECTED + N_RANDOM;
	localparam int          WORD_W       = $bits(word_t);
	localparam int          WORDS        = $bits(line_t) / WORD_W;
	localparam int          SHADOW_WORDS = 256;	// tags 0..7 as far as the memory reaches
	localparam bit [31:0]   RAND_SEED    = 32'h2a635887;
	localparam bit          OP_READ      = 1'b0;
	localparam bit          OP_WRITE     = 1'b1;
	// two memory round trips per entry plus handshake slack
	localparam int          ENTRY_CYCLES   = 2 * (MEM_LATENCY + 2) + 4;
	localparam int          TIMEOUT_CYCLES = TABLE_LEN * ENTRY_CYCLES + 50;

	logic       clk;
	logic       rst_n;
	logic       proc_read;
	logic       proc_write;
	word_addr_t proc_addr;
	word_t      proc_wdata;
	word_t      proc_rdata;
	logic       proc_stall;
	logic       mem_read;
	logic       mem_write;
	line_addr_t mem_addr;
	line_t      mem_wdata;
	line_t      mem_rdata;
	logic       mem_ready;

	bit         op_tab    [TABLE_LEN];	// stimulus table
	word_addr_t addr_tab  [TABLE_LEN];
	word_t      wdata_tab [TABLE_LEN];
	word_t      shadow    [SHADOW_WORDS];
	logic       res_valid [8];	// which tag each line should hold
	tag_t       res_tag   [8];
	int         n_errors;
	int         n_pass;
	int         n_fail;

	dcache_top dcache_top_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_proc_read  (proc_read),
		.i_proc_write (proc_write),
		.i_proc_addr  (proc_addr),
		.i_proc_wdata (proc_wdata),
		.o_proc_rdata (proc_rdata),
		.o_proc_stall (proc_stall),
		.o_mem_read   (mem_read),
		.o_mem_write  (mem_write),
		.o_mem_addr   (mem_addr),
		.o_mem_wdata  (mem_wdata),
		.i_mem_rdata  (mem_rdata),
		.i_mem_ready  (mem_ready)
	);

	slow_mem_model #(.LATENCY(MEM_LATENCY)) slow_mem_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_read  (mem_read),
		.i_write (mem_write),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata),
		.o_ready (mem_ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	function automatic word_t init_word(input word_addr_t a);
		return word_t'(a) * 32'h9e37_79b1 + 32'h0bad_f00d;	// memory's reset contents
	endfunction

	function automatic word_addr_t make_addr(input tag_t t, input index_t ix, input offset_t off);
		return {t, ix, off};
	endfunction

	function automatic int shadow_index(input tag_t t, input index_t ix, input offset_t off);
		return int'({t[2:0], ix, off});
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		n_errors++;
	endtask

	task automatic load_directed();
		op_tab[0]   = OP_READ;
		addr_tab[0] = make_addr(1, 2, 1);	// cold miss
		op_tab[1]   = OP_READ;
		addr_tab[1] = make_addr(1, 2, 3);	// hit in the same line
		op_tab[2]   = OP_WRITE;
		addr_tab[2] = make_addr(1, 2, 2);
		op_tab[3]   = OP_READ;
		addr_tab[3] = make_addr(1, 2, 2);
		op_tab[4]   = OP_READ;
		addr_tab[4] = make_addr(5, 2, 0);	// evicts the written line
		op_tab[5]   = OP_READ;
		addr_tab[5] = make_addr(1, 2, 2);	// written word back from memory
		op_tab[6]   = OP_WRITE;
		addr_tab[6] = make_addr(3, 6, 0);	// cold write miss
		op_tab[7]   = OP_READ;
		addr_tab[7] = make_addr(3, 6, 0);
		for (int n = 0; n < N_DIRECTED; n++) begin
			wdata_tab[n] = '0;
		end
		wdata_tab[2] = 32'hcafe_0001;
		wdata_tab[6] = 32'h5eed_0006;
	endtask

	// random traffic on three indices keeps lines fighting
	task automatic append_random();
		index_t ix;
		for (int n = N_DIRECTED; n < TABLE_LEN; n++) begin
			case ($urandom_range(0, 2))
				0: ix = 3'd2;
				1: ix = 3'd5;
				default: ix = 3'd6;
			endcase
			op_tab[n]    = bit'($urandom_range(0, 1));
			addr_tab[n]  = make_addr(tag_t'($urandom_range(0, 7)), ix,
				offset_t'($urandom_range(0, 3)));
			wdata_tab[n] = $urandom;
		end
	endtask

	// ------------------------------------------------------------------------
	// one table entry is entered and left at a falling edge
	// ------------------------------------------------------------------------

	task automatic run_entry(input int n);
		tag_t    t;
		index_t  ix;
		offset_t off;
		tag_t    victim;
		logic    exp_hit;
		logic    exp_wb;
		line_t   exp_line;
		word_t   exp_word;
		int      wb_seen;
		int      fill_seen;
		int      cycles;
		int      errs_before;
		string   kind;

		errs_before = n_errors;
		{t, ix, off} = addr_tab[n];
		exp_hit  = res_valid[ix] && (res_tag[ix] == t);
		exp_wb   = res_valid[ix] && !exp_hit;
		victim   = res_tag[ix];
		exp_line = '0;
		if (exp_wb) begin
			for (int w = 0; w < WORDS; w++) begin
				exp_line[w*WORD_W +: WORD_W] = shadow[shadow_index(victim, ix, offset_t'(w))];
			end
		end
		kind = exp_hit ? "hit" : (exp_wb ? "write-back and fill" : "fill");
		wb_seen   = 0;
		fill_seen = 0;
		cycles    = 0;
		proc_read  = (op_tab[n] == OP_READ);
		proc_write = (op_tab[n] == OP_WRITE);
		proc_addr  = addr_tab[n];
		proc_wdata = wdata_tab[n];
		do begin
			@(negedge clk);
			cycles++;
			if (mem_ready && mem_write) begin
				wb_seen++;
				if (exp_wb && (mem_addr != {victim, ix}))
					report_mismatch($sformatf("test %0d write-back addr %h", n, mem_addr));
				if (exp_wb && (mem_wdata != exp_line))
					report_mismatch($sformatf("test %0d write-back data %h, expected %h",
						n, mem_wdata, exp_line));
			end
			if (mem_ready && mem_read) begin
				fill_seen++;
				if (mem_addr != {t, ix})
					report_mismatch($sformatf("test %0d fill addr %h", n, mem_addr));
				if (exp_wb && (wb_seen == 0))
					report_mismatch($sformatf("test %0d fill before write-back", n));
			end
		end while (proc_stall);
		// accepted at the next rising edge
		if (wb_seen != (exp_wb ? 1 : 0))
			report_mismatch($sformatf("test %0d saw %0d write-backs", n, wb_seen));
		if (fill_seen != (exp_hit ? 0 : 1))
			report_mismatch($sformatf("test %0d saw %0d fills", n, fill_seen));
		if (exp_hit && (cycles != 1))
			report_mismatch($sformatf("test %0d hit stalled %0d cycles", n, cycles - 1));
		if (mem_read || mem_write)
			report_mismatch($sformatf("test %0d memory busy at accept", n));
		if (op_tab[n] == OP_READ) begin
			exp_word = shadow[shadow_index(t, ix, off)];
			if (proc_rdata !== exp_word)
				report_mismatch($sformatf("test %0d read %h, expected %h",
					n, proc_rdata, exp_word));
		end else begin
			shadow[shadow_index(t, ix, off)] = wdata_tab[n];
		end
		res_valid[ix] = 1'b1;
		res_tag[ix]   = t;
		@(negedge clk);
		if (n_errors == errs_before) begin
			n_pass++;
		end else begin
			n_fail++;
		end
		$display("test %0d %s %h (%s): %s", n, (op_tab[n] == OP_READ) ? "read" : "write",
			addr_tab[n], kind, (n_errors == errs_before) ? "ok" : "error");
	endtask

	// ------------------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------------------

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		n_errors   = 0;
		n_pass     = 0;
		n_fail     = 0;
		void'($urandom(RAND_SEED));
		for (int i = 0; i < SHADOW_WORDS; i++) begin
			shadow[i] = init_word(word_addr_t'(i));
		end
		for (int i = 0; i < 8; i++) begin
			res_valid[i] = 1'b0;
		end
		load_directed();
		append_random();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (mem_read || mem_write || proc_stall) begin
			report_mismatch("outputs active after reset with no request");
			n_fail++;
		end else begin
			n_pass++;
		end
		$display("test reset idle: %s", (n_errors == 0) ? "ok" : "error");
		for (int n = 0; n < TABLE_LEN; n++) begin
			run_entry(n);
		end
		proc_read  = 1'b0;
		proc_write = 1'b0;
		if (dcache_top_i.dcache_sva_i.fail_count != 0) begin
			$display("handshake assertions failed %0d times",
				dcache_top_i.dcache_sva_i.fail_count);
			n_errors++;
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			n_pass + n_fail, n_pass, n_fail, n_errors);
		if (n_errors == 0 && n_fail == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the run hung, the cache never finished within %0d cycles",
			TIMEOUT_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* verif/slow_mem_model.sv */
// behavioral line memory with fixed latency and a one-cycle ready

`timescale 1ns/10ps

module slow_mem_model #(
	parameter int LATENCY = 3	// cycles from request to ready
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_read,
	input  logic                  i_write,
	input  cache_pkg::line_addr_t  i_addr,
	input  cache_pkg::line_t       i_wdata,
	output cache_pkg::line_t       o_rdata,
	output logic                  o_ready
);

	import cache_pkg::*;

	localparam int NUM_LINES = 64;	// tags 0..7 across all 8 indices
	localparam int WORD_W    = $bits(word_t);
	localparam int WORDS     = $bits(line_t) / WORD_W;

	line_t       mem [NUM_LINES];
	int unsigned count_q;

	// every word starts as a scramble of its own word address
	function automatic word_t init_word(input word_addr_t a);
		return word_t'(a) * 32'h9e37_79b1 + 32'h0bad_f00d;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= 0;
			o_ready <= 1'b0;
			o_rdata <= '0;
			for (int l = 0; l < NUM_LINES; l++) begin
				for (int w = 0; w < WORDS; w++) begin
					mem[l][w*WORD_W +: WORD_W] <= init_word(word_addr_t'(l * WORDS + w));
				end
			end
		end else begin
			o_ready <= 1'b0;	// one cycle only
			if ((i_read || i_write) && !o_ready) begin
				if (count_q == LATENCY - 1) begin
					count_q <= 0;
					o_ready <= 1'b1;
					if (i_write) begin
						mem[i_addr[5:0]] <= i_wdata;
					end else begin
						o_rdata <= mem[i_addr[5:0]];
					end
				end else begin
					count_q <= count_q + 1;
				end
			end
		end
	end

endmodule
